// File: project.f
verilog/cd_pkg.sv
verilog/cd_write_decode.sv
verilog/cd_read_decode.sv
verilog/cd_hazard_match.sv
verilog/cd_stall_control.sv
verilog/conflict_detector.sv
sim/conflict_detector_assert.sv
sim/conflict_detector_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the conflict detector testbench with Verilator
verilator --binary --assert --timing --top-module conflict_detector_tb \
    -f project.f -o conflict_detector_sim || exit 1
./obj_dir/conflict_detector_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// File: sim/conflict_detector_tb.sv
`default_nettype none

module conflict_detector_tb;
    import cd_pkg::*;

    localparam int          RANDOM_VECTORS = 200;
    localparam logic [15:0] LFSR_SEED      = 16'd66;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;

    // if_valid down to wb_valid
    localparam pipe_ctrl_t RUN       = 8'hFF;
    localparam pipe_ctrl_t ID_STALL  = 8'h0F;
    localparam pipe_ctrl_t EXE_STALL = 8'h93;
    localparam pipe_ctrl_t MEM_STALL = 8'h94;

    logic       clk;
    logic       reset;
    id_stage_t  id_stage;
    exe_stage_t exe_stage;
    mem_stage_t mem_stage;
    wb_stage_t  wb_stage;
    pipe_ctrl_t pipe_ctrl;
    logic       ebreak_halt;

    logic [15:0] lfsr_state;
    int          pass_count;
    int          fail_count;

    string      row_name [$];
    id_stage_t  row_id [$];
    exe_stage_t row_exe [$];
    mem_stage_t row_mem [$];
    wb_stage_t  row_wb [$];
    pipe_ctrl_t row_ctrl [$];
    logic       row_halt [$];

    conflict_detector conflict_detector_inst (
        .id_stage    (id_stage),
        .exe_stage   (exe_stage),
        .mem_stage   (mem_stage),
        .wb_stage    (wb_stage),
        .pipe_ctrl   (pipe_ctrl),
        .ebreak_halt (ebreak_halt)
    );

    bind conflict_detector conflict_detector_assert assert_inst (
        .clk         (conflict_detector_tb.clk),
        .reset       (conflict_detector_tb.reset),
        .pipe_ctrl   (pipe_ctrl),
        .ebreak_halt (ebreak_halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #200000;
        $display("Timeout: the run did not reach its end");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic id_stage_t id_instr(cd_ctrl_t cd_ctrl, reg_idx_t rs1, reg_idx_t rs2);
        return '{valid: 1'b1, cd_ctrl: cd_ctrl, rs1: rs1, rs2: rs2};
    endfunction

    function automatic exe_stage_t exe_instr(exe_src_t src, wb_ctrl_t wb_ctrl, reg_idx_t rd,
                                             reg_idx_t rs1, reg_idx_t rs2, csr_addr_t csr);
        return '{valid: 1'b1, exe_ctrl: 5'h01, exe_src: src, wb_ctrl: wb_ctrl,
                 rd: rd, rs1: rs1, rs2: rs2, csr: csr};
    endfunction

    function automatic mem_stage_t mem_instr(mem_ctrl_t mem_ctrl, wb_ctrl_t wb_ctrl,
                                             reg_idx_t rd, reg_idx_t rs2, csr_addr_t csr);
        return '{valid: 1'b1, mem_ctrl: mem_ctrl, wb_ctrl: wb_ctrl, rd: rd, rs2: rs2, csr: csr};
    endfunction

    function automatic wb_stage_t wb_instr(wb_ctrl_t wb_ctrl, reg_idx_t rd, csr_addr_t csr);
        return '{valid: 1'b1, wb_ctrl: wb_ctrl, rd: rd, csr: csr};
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [47:0] random_word();
        logic [47:0] bits;
        bits = '0;
        for (int i = 0; i < 48; i++) begin
            bits = {bits[46:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic csr_addr_t pick_csr(logic [1:0] sel);
        case (sel)
            2'd0:    return CSR_MSTATUS;
            2'd1:    return CSR_MTVEC;
            2'd2:    return CSR_MEPC;
            default: return 12'h340; // mscratch
        endcase
    endfunction

    // Expected {pipe_ctrl, ebreak_halt}
    function automatic logic [8:0] model_outputs(id_stage_t id, exe_stage_t ex,
                                                 mem_stage_t mm, wb_stage_t wb);
        logic       wr_valid [3];
        wb_ctrl_t   wr_ctrl [3];
        reg_idx_t   wr_rd [3];
        csr_addr_t  wr_csr [3];
        logic       rd1 [3];
        logic       rd2 [3];
        logic       rdc [3];
        reg_idx_t   src1 [3];
        reg_idx_t   src2 [3];
        csr_addr_t  src_csr [3];
        logic       hit [3];
        logic       active;
        logic       ebreak;
        logic       hold;
        pipe_ctrl_t ctrl;

        wr_valid = '{ex.valid, mm.valid, wb.valid}; // Writers EXE, MEM, WB
        wr_ctrl  = '{ex.wb_ctrl, mm.wb_ctrl, wb.wb_ctrl};
        wr_rd    = '{ex.rd, mm.rd, wb.rd};
        wr_csr   = '{ex.csr, mm.csr, wb.csr};

        // Readers ID, EXE, MEM
        active = ex.valid && ex.exe_ctrl != EXE_NOP;
        rd1 = '{id.valid && id.cd_ctrl inside {CD_BRANCHES, CD_JALR},
                active && ex.exe_src inside {EXE_R_R, EXE_R_I, EXE_R_CSR, EXE_NOTR_CSR},
                1'b0};
        rd2 = '{id.valid && id.cd_ctrl == CD_BRANCHES,
                active && ex.exe_src == EXE_R_R,
                mm.valid && mm.mem_ctrl inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD}};
        rdc = '{id.valid && id.cd_ctrl inside {CD_ECALL, CD_MRET},
                active && ex.exe_src inside {EXE_R_CSR, EXE_NOTR_CSR,
                                             EXE_CSR_ZIMM, EXE_CSR_NOTZIMM},
                1'b0};
        src1    = '{id.rs1, ex.rs1, 5'd0};
        src2    = '{id.rs2, ex.rs2, mm.rs2};
        src_csr = '{(id.cd_ctrl == CD_ECALL) ? CSR_MTVEC : CSR_MEPC, ex.csr, 12'h000};

        for (int r = 0; r < 3; r++) begin
            hit[r] = 1'b0;
            for (int w = r; w < 3; w++) begin // Only stages further down
                if (wr_valid[w]) begin
                    if (wr_ctrl[w] inside {WB_EXE, WB_MEM, WB_IMM, WB_SNPC,
                                           WB_CSRRW, WB_CSRRS, WB_CSRRWI} &&
                        ((rd1[r] && src1[r] == wr_rd[w]) || (rd2[r] && src2[r] == wr_rd[w])))
                        hit[r] = 1'b1;
                    if (rdc[r] && wr_ctrl[w] inside {WB_CSRRW, WB_CSRRS, WB_CSRRWI} &&
                        src_csr[r] == wr_csr[w])
                        hit[r] = 1'b1;
                    if (rdc[r] && wr_ctrl[w] == WB_ECALL &&
                        src_csr[r] inside {CSR_MEPC, CSR_MCAUSE, CSR_MSTATUS})
                        hit[r] = 1'b1;
                end
            end
        end

        ebreak = id.valid && id.cd_ctrl == CD_EBREAK;
        hold   = hit[1] || hit[2];
        ctrl.if_valid   = !(hit[0] || ebreak);
        ctrl.if_enable  = !(hit[0] || ebreak || hold);
        ctrl.id_enable  = ctrl.if_enable;
        ctrl.exe_valid  = ctrl.if_valid;
        ctrl.exe_enable = !hold;
        ctrl.mem_valid  = !hit[1];
        ctrl.mem_enable = !hit[2];
        ctrl.wb_valid   = !hit[2];
        return {ctrl, ebreak && !ex.valid && !mm.valid && !wb.valid};
    endfunction

    task automatic add_row(string name, id_stage_t id, exe_stage_t ex, mem_stage_t mm,
                           wb_stage_t wb, pipe_ctrl_t ctrl, logic halt);
        row_name.push_back(name);
        row_id.push_back(id);
        row_exe.push_back(ex);
        row_mem.push_back(mm);
        row_wb.push_back(wb);
        row_ctrl.push_back(ctrl);
        row_halt.push_back(halt);
    endtask

    task automatic build_table();
        add_row("idle", '0, '0, '0, '0, RUN, 1'b0);
        add_row("disjoint", id_instr(CD_BRANCHES, 5'd1, 5'd2),
                exe_instr(EXE_R_R, WB_EXE, 5'd3, 5'd4, 5'd5, 12'h000),
                mem_instr(MEM_SW, WB_NOP, 5'd0, 5'd7, 12'h000),
                wb_instr(WB_EXE, 5'd8, 12'h000), RUN, 1'b0);
        add_row("id_rs2_exe", id_instr(CD_BRANCHES, 5'd1, 5'd9),
                exe_instr(EXE_R_I, WB_EXE, 5'd9, 5'd10, 5'd11, 12'h000),
                '0, '0, ID_STALL, 1'b0);
        add_row("id_rs2_mem", id_instr(CD_BRANCHES, 5'd1, 5'd9), '0,
                mem_instr(MEM_NOP, WB_MEM, 5'd9, 5'd0, 12'h000), '0, ID_STALL, 1'b0);
        add_row("id_rs2_wb", id_instr(CD_BRANCHES, 5'd1, 5'd9), '0, '0,
                wb_instr(WB_EXE, 5'd9, 12'h000), ID_STALL, 1'b0);
        add_row("id_rs2_ecall_writer", id_instr(CD_BRANCHES, 5'd1, 5'd9),
                exe_instr(EXE_SRC_NOP, WB_ECALL, 5'd9, 5'd0, 5'd0, 12'h000),
                '0, '0, RUN, 1'b0);
        add_row("exe_rr_load", '0, exe_instr(EXE_R_R, WB_EXE, 5'd5, 5'd3, 5'd4, 12'h000),
                mem_instr(MEM_NOP, WB_MEM, 5'd4, 5'd0, 12'h000), '0, EXE_STALL, 1'b0);
        add_row("exe_csr_wb", '0, exe_instr(EXE_R_CSR, WB_CSRRS, 5'd6, 5'd2, 5'd0, 12'h340),
                '0, wb_instr(WB_CSRRS, 5'd7, 12'h340), EXE_STALL, 1'b0);
        add_row("exe_mcause_wb_ecall", '0,
                exe_instr(EXE_CSR_ZIMM, WB_CSRRWI, 5'd1, 5'd0, 5'd0, CSR_MCAUSE),
                '0, wb_instr(WB_ECALL, 5'd0, 12'h000), EXE_STALL, 1'b0);
        add_row("id_mret_mem_ecall", id_instr(CD_MRET, 5'd0, 5'd0), '0,
                mem_instr(MEM_NOP, WB_ECALL, 5'd0, 5'd0, 12'h000), '0, ID_STALL, 1'b0);
        add_row("id_ecall_mem_ecall", id_instr(CD_ECALL, 5'd0, 5'd0), '0,
                mem_instr(MEM_NOP, WB_ECALL, 5'd0, 5'd0, 12'h000), '0, RUN, 1'b0);
        add_row("id_ecall_mtvec_write", id_instr(CD_ECALL, 5'd0, 5'd0), '0, '0,
                wb_instr(WB_CSRRW, 5'd1, CSR_MTVEC), ID_STALL, 1'b0);
        add_row("mem_store_wb", '0, '0, mem_instr(MEM_SW, WB_NOP, 5'd0, 5'd12, 12'h000),
                wb_instr(WB_MEM, 5'd12, 12'h000), MEM_STALL, 1'b0);
        add_row("ebreak_busy", id_instr(CD_EBREAK, 5'd0, 5'd0),
                exe_instr(EXE_SRC_NOP, WB_NOP, 5'd0, 5'd0, 5'd0, 12'h000),
                '0, '0, ID_STALL, 1'b0);
        add_row("ebreak_drained", id_instr(CD_EBREAK, 5'd0, 5'd0), '0, '0, '0,
                ID_STALL, 1'b1);
    endtask

    task automatic wait_outputs_known(output logic known);
        int steps;
        steps = 0;
        while ($isunknown({pipe_ctrl, ebreak_halt}) && steps < 20) begin
            #1;
            steps++;
        end
        known = !$isunknown({pipe_ctrl, ebreak_halt});
    endtask

    task automatic run_test(string name, id_stage_t id, exe_stage_t ex, mem_stage_t mm,
                            wb_stage_t wb, pipe_ctrl_t exp_ctrl, logic exp_halt);
        logic ok;
        logic known;
        ok = 1'b1;
        @(posedge clk);
        #10;
        id_stage  = id;
        exe_stage = ex;
        mem_stage = mm;
        wb_stage  = wb;
        #40;
        wait_outputs_known(known);
        assert (known) else begin
            $display("%s: DUT outputs are still unknown after the settling time", name);
            ok = 1'b0;
        end
        assert (pipe_ctrl === exp_ctrl) else begin
            $display("ERROR %s: pipe_ctrl expected %b actual %b", name, exp_ctrl, pipe_ctrl);
            ok = 1'b0;
        end
        assert (ebreak_halt === exp_halt) else begin
            $display("ERROR %s: ebreak_halt expected %b actual %b", name, exp_halt, ebreak_halt);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        logic [47:0] bits;
        logic [8:0]  expected;
        id_stage_t   rid;
        exe_stage_t  rexe;
        mem_stage_t  rmem;
        wb_stage_t   rwb;

        reset      = 1'b1;
        id_stage   = '0;
        exe_stage  = '0;
        mem_stage  = '0;
        wb_stage   = '0;
        pass_count = 0;
        fail_count = 0;
        lfsr_state = LFSR_SEED;
        build_table();
        for (int i = 0; i < 10; i++)
            @(posedge clk);
        #10;
        reset = 1'b0;

        for (int i = 0; i < row_name.size(); i++)
            run_test(row_name[i], row_id[i], row_exe[i], row_mem[i], row_wb[i],
                     row_ctrl[i], row_halt[i]);

        // Two-bit register indices so that matches are common
        for (int n = 0; n < RANDOM_VECTORS; n++) begin
            bits = random_word();
            rid.valid      = bits[0];
            rid.cd_ctrl    = bits[3:1];
            rid.rs1        = {3'b000, bits[5:4]};
            rid.rs2        = {3'b000, bits[7:6]};
            rexe.valid     = bits[8];
            rexe.exe_ctrl  = {4'b0000, bits[9]};
            rexe.exe_src   = bits[12:10];
            rexe.wb_ctrl   = bits[16:13];
            rexe.rd        = {3'b000, bits[18:17]};
            rexe.rs1       = {3'b000, bits[20:19]};
            rexe.rs2       = {3'b000, bits[22:21]};
            rexe.csr       = pick_csr(bits[24:23]);
            rmem.valid     = bits[25];
            rmem.mem_ctrl  = {1'b0, bits[28:26]};
            rmem.wb_ctrl   = bits[32:29];
            rmem.rd        = {3'b000, bits[34:33]};
            rmem.rs2       = {3'b000, bits[36:35]};
            rmem.csr       = pick_csr(bits[38:37]);
            rwb.valid      = bits[39];
            rwb.wb_ctrl    = bits[43:40];
            rwb.rd         = {3'b000, bits[45:44]};
            rwb.csr        = pick_csr(bits[47:46]);
            expected = model_outputs(rid, rexe, rmem, rwb);
            run_test($sformatf("random_%0d", n), rid, rexe, rmem, rwb,
                     expected[8:1], expected[0]);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/conflict_detector_assert.sv
`default_nettype none

module conflict_detector_assert (
    input logic               clk,
    input logic               reset,
    input cd_pkg::pipe_ctrl_t pipe_ctrl,
    input logic               ebreak_halt
);

    // Holding MEM freezes everything behind it
    mem_hold_freezes_exe: assert property (@(posedge clk) disable iff (reset)
        !pipe_ctrl.mem_enable |-> !pipe_ctrl.exe_enable && !pipe_ctrl.wb_valid)
        else $error("MEM held while EXE runs or WB gets a valid slot");

    exe_hold_freezes_id: assert property (@(posedge clk) disable iff (reset)
        !pipe_ctrl.exe_enable |-> !pipe_ctrl.id_enable)
        else $error("EXE held while ID keeps advancing");

    halt_stops_fetch: assert property (@(posedge clk) disable iff (reset)
        ebreak_halt |-> !pipe_ctrl.if_enable)
        else $error("ebreak halt raised while fetch is still enabled");

endmodule

`default_nettype wire

// File: verilog/conflict_detector.sv
`default_nettype none

module conflict_detector (
    input  cd_pkg::id_stage_t  id_stage,
    input  cd_pkg::exe_stage_t exe_stage,
    input  cd_pkg::mem_stage_t mem_stage,
    input  cd_pkg::wb_stage_t  wb_stage,
    output cd_pkg::pipe_ctrl_t pipe_ctrl,
    output logic               ebreak_halt
);
    import cd_pkg::*;

    write_info_t exe_write;
    write_info_t mem_write;
    write_info_t wb_write;

    read_info_t id_read;
    read_info_t exe_read;
    read_info_t mem_read;

    logic hit_id_exe;
    logic hit_id_mem;
    logic hit_id_wb;
    logic hit_exe_mem;
    logic hit_exe_wb;
    logic hit_mem_wb;

    logic id_hit;
    logic exe_hit;
    logic mem_hit;

    cd_write_decode exe_write_decode_inst (
        .stage_valid (exe_stage.valid),
        .wb_ctrl     (exe_stage.wb_ctrl),
        .rd          (exe_stage.rd),
        .csr         (exe_stage.csr),
        .write       (exe_write)
    );

    cd_write_decode mem_write_decode_inst (
        .stage_valid (mem_stage.valid),
        .wb_ctrl     (mem_stage.wb_ctrl),
        .rd          (mem_stage.rd),
        .csr         (mem_stage.csr),
        .write       (mem_write)
    );

    cd_write_decode wb_write_decode_inst (
        .stage_valid (wb_stage.valid),
        .wb_ctrl     (wb_stage.wb_ctrl),
        .rd          (wb_stage.rd),
        .csr         (wb_stage.csr),
        .write       (wb_write)
    );

    cd_read_decode read_decode_inst (
        .id_stage  (id_stage),
        .exe_stage (exe_stage),
        .mem_stage (mem_stage),
        .id_read   (id_read),
        .exe_read  (exe_read),
        .mem_read  (mem_read)
    );

    // Each reader against every stage behind it
    cd_hazard_match id_exe_match_inst  (.reader(id_read),  .writer(exe_write), .hit(hit_id_exe));
    cd_hazard_match id_mem_match_inst  (.reader(id_read),  .writer(mem_write), .hit(hit_id_mem));
    cd_hazard_match id_wb_match_inst   (.reader(id_read),  .writer(wb_write),  .hit(hit_id_wb));
    cd_hazard_match exe_mem_match_inst (.reader(exe_read), .writer(mem_write), .hit(hit_exe_mem));
    cd_hazard_match exe_wb_match_inst  (.reader(exe_read), .writer(wb_write),  .hit(hit_exe_wb));
    cd_hazard_match mem_wb_match_inst  (.reader(mem_read), .writer(wb_write),  .hit(hit_mem_wb));

    assign id_hit  = hit_id_exe | hit_id_mem | hit_id_wb;
    assign exe_hit = hit_exe_mem | hit_exe_wb;
    assign mem_hit = hit_mem_wb;

    cd_stall_control stall_control_inst (
        .id_hit       (id_hit),
        .exe_hit      (exe_hit),
        .mem_hit      (mem_hit),
        .id_stage     (id_stage),
        .exe_valid_in (exe_stage.valid),
        .mem_valid_in (mem_stage.valid),
        .wb_valid_in  (wb_stage.valid),
        .pipe_ctrl    (pipe_ctrl),
        .ebreak_halt  (ebreak_halt)
    );

endmodule

`default_nettype wire

// File: verilog/cd_stall_control.sv
`default_nettype none

module cd_stall_control (
    input  logic               id_hit,
    input  logic               exe_hit,
    input  logic               mem_hit,
    input  cd_pkg::id_stage_t  id_stage,
    input  logic               exe_valid_in,
    input  logic               mem_valid_in,
    input  logic               wb_valid_in,
    output cd_pkg::pipe_ctrl_t pipe_ctrl,
    output logic               ebreak_halt
);
    import cd_pkg::*;

    logic ebreak;
    logic id_stall;
    logic exe_stall;

    assign ebreak = id_stage.valid & (id_stage.cd_ctrl == CD_EBREAK);

    // ebreak holds ID exactly like an ID operand hazard
    assign id_stall  = id_hit | ebreak;
    assign exe_stall = exe_hit | mem_hit; // Both freeze EXE

    always_comb begin
        pipe_ctrl.if_valid   = ~id_stall;
        pipe_ctrl.if_enable  = ~(id_stall | exe_stall);
        pipe_ctrl.id_enable  = ~(id_stall | exe_stall);
        pipe_ctrl.exe_valid  = ~id_stall;  // Bubble into EXE
        pipe_ctrl.exe_enable = ~exe_stall;
        pipe_ctrl.mem_valid  = ~exe_hit;
        pipe_ctrl.mem_enable = ~mem_hit;
        pipe_ctrl.wb_valid   = ~mem_hit;
    end

    // Everything ahead of the ebreak has retired
    assign ebreak_halt = ebreak & ~exe_valid_in & ~mem_valid_in & ~wb_valid_in;

endmodule

`default_nettype wire

// File: verilog/cd_hazard_match.sv
`default_nettype none

module cd_hazard_match (
    input  cd_pkg::read_info_t  reader,
    input  cd_pkg::write_info_t writer,
    output logic                hit
);
    import cd_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic csr_hit;
    logic trap_csr;
    logic ecall_hit;

    assign rs1_hit = reader.rs1_read & writer.rd_write & (reader.rs1 == writer.rd);
    assign rs2_hit = reader.rs2_read & writer.rd_write & (reader.rs2 == writer.rd);
    assign csr_hit = reader.csr_read & writer.csr_write & (reader.csr == writer.csr);

    // An ecall updates these three on its way out
    assign trap_csr = (reader.csr == CSR_MEPC) ||
                      (reader.csr == CSR_MCAUSE) ||
                      (reader.csr == CSR_MSTATUS);

    assign ecall_hit = reader.csr_read & writer.ecall_write & trap_csr;

    assign hit = rs1_hit | rs2_hit | csr_hit | ecall_hit;

endmodule

`default_nettype wire

// File: verilog/cd_read_decode.sv
`default_nettype none

module cd_read_decode (
    input  cd_pkg::id_stage_t  id_stage,
    input  cd_pkg::exe_stage_t exe_stage,
    input  cd_pkg::mem_stage_t mem_stage,
    output cd_pkg::read_info_t id_read,
    output cd_pkg::read_info_t exe_read,
    output cd_pkg::read_info_t mem_read
);
    import cd_pkg::*;

    logic exe_active;

    // ID: branch operands and the trap vector / return address CSRs
    always_comb begin
        id_read.rs1_read = id_stage.valid &
                           (id_stage.cd_ctrl == CD_BRANCHES || id_stage.cd_ctrl == CD_JALR);
        id_read.rs2_read = id_stage.valid & (id_stage.cd_ctrl == CD_BRANCHES);
        id_read.csr_read = id_stage.valid &
                           (id_stage.cd_ctrl == CD_ECALL || id_stage.cd_ctrl == CD_MRET);
        id_read.rs1      = id_stage.rs1;
        id_read.rs2      = id_stage.rs2;
        id_read.csr      = (id_stage.cd_ctrl == CD_ECALL) ? CSR_MTVEC : CSR_MEPC;
    end

    assign exe_active = exe_stage.valid & (exe_stage.exe_ctrl != EXE_NOP);

    always_comb begin
        exe_read.rs1_read = 1'b0;
        exe_read.rs2_read = 1'b0;
        exe_read.csr_read = 1'b0;
        exe_read.rs1      = exe_stage.rs1;
        exe_read.rs2      = exe_stage.rs2;
        exe_read.csr      = exe_stage.csr;
        if (exe_active) begin
            case (exe_stage.exe_src)
                EXE_R_R: begin
                    exe_read.rs1_read = 1'b1;
                    exe_read.rs2_read = 1'b1;
                end
                EXE_R_I: begin
                    exe_read.rs1_read = 1'b1;
                end
                EXE_R_CSR, EXE_NOTR_CSR: begin
                    exe_read.rs1_read = 1'b1;
                    exe_read.csr_read = 1'b1;
                end
                EXE_CSR_ZIMM, EXE_CSR_NOTZIMM: begin
                    exe_read.csr_read = 1'b1; // Immediate operand
                end
                default: ; // EXE_SRC_NOP, EXE_PC_I
            endcase
        end
    end

    // MEM only reads store data
    always_comb begin
        mem_read.rs1_read = 1'b0;
        mem_read.csr_read = 1'b0;
        mem_read.rs1      = '0;
        mem_read.rs2      = mem_stage.rs2;
        mem_read.csr      = mem_stage.csr;
        case (mem_stage.mem_ctrl)
            MEM_SB, MEM_SH, MEM_SW, MEM_SD: mem_read.rs2_read = mem_stage.valid;
            default:                        mem_read.rs2_read = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cd_write_decode.sv
`default_nettype none

module cd_write_decode (
    input  logic                stage_valid,
    input  cd_pkg::wb_ctrl_t    wb_ctrl,
    input  cd_pkg::reg_idx_t    rd,
    input  cd_pkg::csr_addr_t   csr,
    output cd_pkg::write_info_t write
);
    import cd_pkg::*;

    logic is_csr_op;
    logic is_rd_op;

    always_comb begin
        is_csr_op = 1'b0;
        is_rd_op  = 1'b0;
        case (wb_ctrl)
            WB_EXE, WB_MEM, WB_IMM, WB_SNPC: begin
                is_rd_op = 1'b1;
            end
            WB_CSRRW, WB_CSRRS, WB_CSRRWI: begin
                is_rd_op  = 1'b1; // Old CSR value goes to rd
                is_csr_op = 1'b1;
            end
            default: ;
        endcase
    end

    assign write.rd_write    = stage_valid & is_rd_op;
    assign write.csr_write   = stage_valid & is_csr_op;
    assign write.ecall_write = stage_valid & (wb_ctrl == WB_ECALL);
    assign write.rd          = rd;
    assign write.csr         = csr;

endmodule

`default_nettype wire

// File: verilog/cd_pkg.sv
`default_nettype none

package cd_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    // ID decode class
    typedef logic [2:0] cd_ctrl_t;
    localparam cd_ctrl_t CD_NONE     = 3'b000;
    localparam cd_ctrl_t CD_BRANCHES = 3'b001;
    localparam cd_ctrl_t CD_JALR     = 3'b010;
    localparam cd_ctrl_t CD_ECALL    = 3'b011;
    localparam cd_ctrl_t CD_MRET     = 3'b100;
    localparam cd_ctrl_t CD_EBREAK   = 3'b101;

    typedef logic [4:0] exe_ctrl_t;
    localparam exe_ctrl_t EXE_NOP = 5'b00000;

    // ALU operand source
    typedef logic [2:0] exe_src_t;
    localparam exe_src_t EXE_SRC_NOP     = 3'b000;
    localparam exe_src_t EXE_R_R         = 3'b001;
    localparam exe_src_t EXE_R_I         = 3'b010;
    localparam exe_src_t EXE_PC_I        = 3'b011;
    localparam exe_src_t EXE_R_CSR       = 3'b100;
    localparam exe_src_t EXE_NOTR_CSR    = 3'b101;
    localparam exe_src_t EXE_CSR_ZIMM    = 3'b110;
    localparam exe_src_t EXE_CSR_NOTZIMM = 3'b111;

    typedef logic [3:0] mem_ctrl_t;
    localparam mem_ctrl_t MEM_NOP = 4'b0000; // Loads too
    localparam mem_ctrl_t MEM_SB  = 4'b0001;
    localparam mem_ctrl_t MEM_SH  = 4'b0010;
    localparam mem_ctrl_t MEM_SW  = 4'b0011;
    localparam mem_ctrl_t MEM_SD  = 4'b0100;

    // Writeback source
    typedef logic [3:0] wb_ctrl_t;
    localparam wb_ctrl_t WB_NOP    = 4'b0000;
    localparam wb_ctrl_t WB_EXE    = 4'b0001;
    localparam wb_ctrl_t WB_MEM    = 4'b0010;
    localparam wb_ctrl_t WB_IMM    = 4'b0011;
    localparam wb_ctrl_t WB_SNPC   = 4'b0100;
    localparam wb_ctrl_t WB_CSRRW  = 4'b0101;
    localparam wb_ctrl_t WB_CSRRS  = 4'b0110;
    localparam wb_ctrl_t WB_CSRRWI = 4'b0111;
    localparam wb_ctrl_t WB_ECALL  = 4'b1000;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    typedef struct packed {
        logic     valid;
        cd_ctrl_t cd_ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } id_stage_t;

    typedef struct packed {
        logic      valid;
        exe_ctrl_t exe_ctrl;
        exe_src_t  exe_src;
        wb_ctrl_t  wb_ctrl;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        csr_addr_t csr;
    } exe_stage_t;

    typedef struct packed {
        logic      valid;
        mem_ctrl_t mem_ctrl;
        wb_ctrl_t  wb_ctrl;
        reg_idx_t  rd;
        reg_idx_t  rs2;
        csr_addr_t csr;
    } mem_stage_t;

    typedef struct packed {
        logic      valid;
        wb_ctrl_t  wb_ctrl;
        reg_idx_t  rd;
        csr_addr_t csr;
    } wb_stage_t;

    // What a stage is going to write
    typedef struct packed {
        logic      rd_write;
        logic      csr_write;
        logic      ecall_write;
        reg_idx_t  rd;
        csr_addr_t csr;
    } write_info_t;

    // What a stage needs to read
    typedef struct packed {
        logic      rs1_read;
        logic      rs2_read;
        logic      csr_read;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        csr_addr_t csr;
    } read_info_t;

    typedef struct packed {
        logic if_valid;
        logic if_enable;
        logic id_enable;
        logic exe_valid;
        logic exe_enable;
        logic mem_valid;
        logic mem_enable;
        logic wb_valid;
    } pipe_ctrl_t;

endpackage

`default_nettype wire
